/* src/riscv_cfg.svh */
// Core configuration macros for widths, register count and reset values
`ifndef RISCV_CFG_SVH
`define RISCV_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////////////////////////

// Data and address width
`define RV_XLEN 32

// Register index width
`define RV_REG_AW 5

// Architectural registers, x0 included
`define RV_NUM_REGS 32

//////////////////////////////////////////////////////////////////////
// Reset values
//////////////////////////////////////////////////////////////////////

// ADDI x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

/* src/riscv_pkg.sv */
// Shared RV32I types, opcodes, function codes and instruction views
`include "riscv_cfg.svh"

package riscv_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // funct3 codes
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;

  // funct7 codes
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } i_type_t;

  // Store immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_type_t;

  // One instruction word, three decodings
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
  } instr_u;

endpackage

/* src/riscv_register_file.sv */
// Register file: 31 general registers, two read ports, one write port
`include "riscv_cfg.svh"

module riscv_register_file (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  riscv_pkg::reg_addr_t raddr_a_i,
  input  riscv_pkg::reg_addr_t raddr_b_i,
  output riscv_pkg::word_t     rdata_a_o,
  output riscv_pkg::word_t     rdata_b_o,
  input  logic                 we_i,
  input  riscv_pkg::reg_addr_t waddr_i,
  input  riscv_pkg::word_t     wdata_i
);
  import riscv_pkg::*;

  word_t regs [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int k = 1; k < `RV_NUM_REGS; k++) begin
        regs[k] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads zero; same-cycle write is seen through forwarding
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

  a_waddr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> !$isunknown(waddr_i));

endmodule

/* src/riscv_if_stage.sv */
// Fetch stage: program counter, instruction request and IF/ID register
`include "riscv_cfg.svh"

module riscv_if_stage (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  riscv_pkg::word_t    boot_addr_i,
  input  logic                stall_i,
  output logic                instr_req_o,
  output riscv_pkg::word_t    instr_addr_o,
  input  riscv_pkg::word_t    instr_rdata_i,
  output riscv_pkg::instr_u   instr_id_o,
  output riscv_pkg::word_t    pc_id_o
);
  import riscv_pkg::*;

  word_t pc_if;
  logic  fetch_on;
  logic  id_valid;

  // Stalled: ask again for the word now in decode
  assign instr_addr_o = stall_i ? pc_id_o : pc_if;
  assign instr_req_o  = fetch_on;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pc_if    <= boot_addr_i;
      fetch_on <= 1'b0;
    end else begin
      fetch_on <= 1'b1;
      if (fetch_on && !stall_i) begin
        pc_if <= pc_if + 32'd4;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////////////////////////

  // Memory output acts as the word half of IF/ID
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      id_valid <= 1'b0;
    end else begin
      id_valid <= fetch_on;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_id_o <= instr_addr_o;
  end

  // NOP until the first word returns
  assign instr_id_o = id_valid ? instr_rdata_i : `RV_NOP;

endmodule

/* src/riscv_id_stage.sv */
// Decode stage: decoder, operand forwarding, load-use stall and ID/EX register
module riscv_id_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  riscv_pkg::instr_u    instr_i,
  input  logic                 hold_i,
  output logic                 stall_o,
  input  riscv_pkg::reg_addr_t ex_waddr_i,
  input  logic                 ex_we_i,
  input  logic                 ex_load_i,
  input  riscv_pkg::word_t     ex_result_i,
  input  logic                 wb_we_i,
  input  riscv_pkg::reg_addr_t wb_waddr_i,
  input  riscv_pkg::word_t     wb_wdata_i,
  output riscv_pkg::alu_op_e   alu_op_ex_o,
  output riscv_pkg::word_t     operand_a_ex_o,
  output riscv_pkg::word_t     operand_b_ex_o,
  output riscv_pkg::word_t     store_data_ex_o,
  output riscv_pkg::reg_addr_t waddr_ex_o,
  output logic                 we_ex_o,
  output logic                 load_ex_o,
  output logic                 store_ex_o
);
  import riscv_pkg::*;

  alu_op_e alu_op;
  logic    we, load, store, use_rs2, use_imm;
  word_t   imm, rf_a, rf_b, fw_a, fw_b;

  //////////////////////////////////////////////////////////////////////
  // Decoder
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op  = ALU_ADD;
    we      = 1'b0;
    load    = 1'b0;
    store   = 1'b0;
    use_rs2 = 1'b0;
    use_imm = 1'b1;
    imm     = {{20{instr_i.i.imm[11]}}, instr_i.i.imm};
    case (opcode_e'(instr_i.r.opcode))
      OP_IMM: begin
        we = 1'b1;
        case (instr_i.i.funct3)
          F3_ADD:  alu_op = ALU_ADD;
          F3_SLT:  alu_op = ALU_SLT;
          F3_XOR:  alu_op = ALU_XOR;
          F3_OR:   alu_op = ALU_OR;
          F3_AND:  alu_op = ALU_AND;
          default: we = 1'b0;
        endcase
      end
      OP: begin
        we      = 1'b1;
        use_rs2 = 1'b1;
        use_imm = 1'b0;
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
          {F7_ALT,  F3_ADD}: alu_op = ALU_SUB;
          {F7_BASE, F3_SLL}: alu_op = ALU_SLL;
          {F7_BASE, F3_SLT}: alu_op = ALU_SLT;
          {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
          {F7_BASE, F3_SR}:  alu_op = ALU_SRL;
          {F7_ALT,  F3_SR}:  alu_op = ALU_SRA;
          {F7_BASE, F3_OR}:  alu_op = ALU_OR;
          {F7_BASE, F3_AND}: alu_op = ALU_AND;
          default:           we = 1'b0;
        endcase
      end
      LUI: begin
        we     = 1'b1;
        alu_op = ALU_PASS_B;
        // Upper 20 bits span imm, rs1 and funct3 of the I view
        imm    = {instr_i.i.imm, instr_i.i.rs1, instr_i.i.funct3, 12'b0};
      end
      LOAD: begin
        we   = (instr_i.i.funct3 == F3_WORD);
        load = (instr_i.i.funct3 == F3_WORD);
      end
      STORE: begin
        store   = (instr_i.s.funct3 == F3_WORD);
        use_rs2 = 1'b1;
        imm     = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
      end
      default: ;
    endcase
    // x0 never written, so never forwarded
    if (instr_i.r.rd == '0) begin
      we = 1'b0;
    end
  end

  riscv_register_file registers_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .raddr_a_i (instr_i.r.rs1),
    .raddr_b_i (instr_i.r.rs2),
    .rdata_a_o (rf_a),
    .rdata_b_o (rf_b),
    .we_i      (wb_we_i),
    .waddr_i   (wb_waddr_i),
    .wdata_i   (wb_wdata_i)
  );

  // EX first, then write-back, then the register file
  always_comb begin
    fw_a = rf_a;
    if (ex_we_i && ex_waddr_i == instr_i.r.rs1) begin
      fw_a = ex_result_i;
    end else if (wb_we_i && wb_waddr_i == instr_i.r.rs1) begin
      fw_a = wb_wdata_i;
    end
    fw_b = rf_b;
    if (ex_we_i && ex_waddr_i == instr_i.r.rs2) begin
      fw_b = ex_result_i;
    end else if (wb_we_i && wb_waddr_i == instr_i.r.rs2) begin
      fw_b = wb_wdata_i;
    end
  end

  // Load in EX has only its address, data not back yet
  assign stall_o = ex_load_i && ex_we_i &&
                   ((ex_waddr_i == instr_i.r.rs1) ||
                    (use_rs2 && ex_waddr_i == instr_i.r.rs2));

  //////////////////////////////////////////////////////////////////////
  // ID/EX register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      we_ex_o    <= 1'b0;
      load_ex_o  <= 1'b0;
      store_ex_o <= 1'b0;
    end else if (!hold_i) begin
      // Bubble on load-use
      we_ex_o    <= we && !stall_o;
      load_ex_o  <= load && !stall_o;
      store_ex_o <= store && !stall_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_i) begin
      alu_op_ex_o     <= alu_op;
      operand_a_ex_o  <= (alu_op == ALU_PASS_B) ? '0 : fw_a;
      operand_b_ex_o  <= use_imm ? imm : fw_b;
      store_data_ex_o <= fw_b;
      waddr_ex_o      <= instr_i.r.rd;
    end
  end

  // Word in decode is fetched again while the LSU waits on the bus
  a_hold_freeze: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    hold_i |=> $stable(instr_i));

endmodule

/* src/riscv_ex_stage.sv */
// Execute stage: ALU and EX/WB pipeline register
module riscv_ex_stage (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 hold_i,
  input  riscv_pkg::alu_op_e   alu_op_i,
  input  riscv_pkg::word_t     operand_a_i,
  input  riscv_pkg::word_t     operand_b_i,
  input  riscv_pkg::word_t     store_data_i,
  input  riscv_pkg::reg_addr_t waddr_i,
  input  logic                 we_i,
  input  logic                 load_i,
  input  logic                 store_i,
  output riscv_pkg::word_t     result_o,
  output riscv_pkg::reg_addr_t waddr_o,
  output logic                 we_o,
  output logic                 load_o,
  output riscv_pkg::word_t     result_wb_o,
  output riscv_pkg::reg_addr_t waddr_wb_o,
  output logic                 we_wb_o,
  output logic                 load_wb_o,
  output riscv_pkg::word_t     store_data_o,
  output logic                 store_o
);
  import riscv_pkg::*;

  logic [4:0] shamt;

  assign shamt = operand_b_i[4:0];

  always_comb begin
    case (alu_op_i)
      ALU_SUB:    result_o = operand_a_i - operand_b_i;
      ALU_SLL:    result_o = operand_a_i << shamt;
      ALU_SLT:    result_o = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
      ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      ALU_SRL:    result_o = operand_a_i >> shamt;
      ALU_SRA:    result_o = word_t'($signed(operand_a_i) >>> shamt);
      ALU_OR:     result_o = operand_a_i | operand_b_i;
      ALU_AND:    result_o = operand_a_i & operand_b_i;
      ALU_PASS_B: result_o = operand_b_i;
      default:    result_o = operand_a_i + operand_b_i;
    endcase
  end

  // Forwarding view of the instruction now in EX
  assign waddr_o = waddr_i;
  assign we_o    = we_i;
  assign load_o  = load_i;

  //////////////////////////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      we_wb_o   <= 1'b0;
      load_wb_o <= 1'b0;
      store_o   <= 1'b0;
    end else if (!hold_i) begin
      we_wb_o   <= we_i;
      load_wb_o <= load_i;
      store_o   <= store_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_i) begin
      result_wb_o  <= result_o;
      waddr_wb_o   <= waddr_i;
      store_data_o <= store_data_i;
    end
  end

endmodule

/* src/riscv_load_store_unit.sv */
// Load store unit: data bus handshake, pipeline hold and register write-back
module riscv_load_store_unit (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  riscv_pkg::word_t     result_i,
  input  riscv_pkg::word_t     store_data_i,
  input  riscv_pkg::reg_addr_t waddr_i,
  input  logic                 we_i,
  input  logic                 load_i,
  input  logic                 store_i,
  output logic                 data_req_o,
  output logic                 data_we_o,
  output riscv_pkg::word_t     data_addr_o,
  output riscv_pkg::word_t     data_wdata_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  riscv_pkg::word_t     data_rdata_i,
  output logic                 hold_o,
  output logic                 wb_we_o,
  output riscv_pkg::reg_addr_t wb_waddr_o,
  output riscv_pkg::word_t     wb_wdata_o
);
  import riscv_pkg::*;

  typedef enum logic {
    S_REQ,
    S_WAIT
  } lsu_state_e;

  lsu_state_e state;

  //////////////////////////////////////////////////////////////////////
  // Bus side
  //////////////////////////////////////////////////////////////////////

  // Address from the ALU, held by the frozen EX/WB register
  assign data_req_o   = (state == S_REQ) && (load_i || store_i);
  assign data_we_o    = store_i;
  assign data_addr_o  = result_i;
  assign data_wdata_o = store_data_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state <= S_REQ;
    end else begin
      case (state)
        S_REQ:   if (data_req_o && data_gnt_i && load_i) state <= S_WAIT;
        S_WAIT:  if (data_rvalid_i) state <= S_REQ;
        default: state <= S_REQ;
      endcase
    end
  end

  // Stores finish on grant, loads on rvalid
  always_comb begin
    if (state == S_WAIT) begin
      hold_o = !data_rvalid_i;
    end else begin
      hold_o = data_req_o && (load_i || !data_gnt_i);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Write-back
  //////////////////////////////////////////////////////////////////////

  // A load to x0 still goes to the bus but writes nothing back
  assign wb_waddr_o = waddr_i;
  assign wb_we_o    = (state == S_WAIT) ? (data_rvalid_i && we_i) : (we_i && !load_i);
  assign wb_wdata_o = (state == S_WAIT) ? data_rdata_i : result_i;

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o));

  a_rvalid_expected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_rvalid_i |-> state == S_WAIT);

endmodule

/* src/riscv_core.sv */
// Top level of the RV32I core, connects fetch, decode, execute and LSU
module riscv_core (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  riscv_pkg::word_t boot_addr_i,
  output logic             instr_req_o,
  output riscv_pkg::word_t instr_addr_o,
  input  riscv_pkg::word_t instr_rdata_i,
  output logic             data_req_o,
  output logic             data_we_o,
  input  logic             data_gnt_i,
  input  logic             data_rvalid_i,
  output riscv_pkg::word_t data_addr_o,
  output riscv_pkg::word_t data_wdata_o,
  input  riscv_pkg::word_t data_rdata_i
);

  // IF/ID
  riscv_pkg::instr_u    instr_id;
  logic                 id_stall;
  logic                 lsu_hold;
  logic                 if_stall;

  // ID/EX
  riscv_pkg::alu_op_e   alu_op_ex;
  riscv_pkg::word_t     operand_a_ex, operand_b_ex, store_data_ex;
  riscv_pkg::reg_addr_t waddr_ex;
  logic                 we_ex, load_ex, store_ex;

  // EX forwarding
  riscv_pkg::word_t     ex_result;
  riscv_pkg::reg_addr_t ex_waddr;
  logic                 ex_we, ex_load;

  // EX/WB to LSU
  riscv_pkg::word_t     result_wb, store_data_wb;
  riscv_pkg::reg_addr_t waddr_wb;
  logic                 we_wb, load_wb, store_wb;

  // Register write port
  logic                 wb_we;
  riscv_pkg::reg_addr_t wb_waddr;
  riscv_pkg::word_t     wb_wdata;

  assign if_stall = id_stall | lsu_hold;

  //////////////////////////////////////////////////////////////////////
  // Stages
  //////////////////////////////////////////////////////////////////////

  riscv_if_stage if_stage_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .boot_addr_i (boot_addr_i),
    .stall_i (if_stall), .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o),
    .instr_rdata_i (instr_rdata_i), .instr_id_o (instr_id), .pc_id_o ()
  );

  riscv_id_stage id_stage_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .instr_i (instr_id),
    .hold_i (lsu_hold), .stall_o (id_stall),
    .ex_waddr_i (ex_waddr), .ex_we_i (ex_we), .ex_load_i (ex_load),
    .ex_result_i (ex_result),
    .wb_we_i (wb_we), .wb_waddr_i (wb_waddr), .wb_wdata_i (wb_wdata),
    .alu_op_ex_o (alu_op_ex), .operand_a_ex_o (operand_a_ex),
    .operand_b_ex_o (operand_b_ex), .store_data_ex_o (store_data_ex),
    .waddr_ex_o (waddr_ex), .we_ex_o (we_ex), .load_ex_o (load_ex),
    .store_ex_o (store_ex)
  );

  riscv_ex_stage ex_stage_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .hold_i (lsu_hold),
    .alu_op_i (alu_op_ex), .operand_a_i (operand_a_ex), .operand_b_i (operand_b_ex),
    .store_data_i (store_data_ex), .waddr_i (waddr_ex), .we_i (we_ex),
    .load_i (load_ex), .store_i (store_ex),
    .result_o (ex_result), .waddr_o (ex_waddr), .we_o (ex_we), .load_o (ex_load),
    .result_wb_o (result_wb), .waddr_wb_o (waddr_wb), .we_wb_o (we_wb),
    .load_wb_o (load_wb), .store_data_o (store_data_wb), .store_o (store_wb)
  );

  riscv_load_store_unit load_store_unit_i (
    .clk_i (clk_i), .rst_n_i (rst_n_i),
    .result_i (result_wb), .store_data_i (store_data_wb), .waddr_i (waddr_wb),
    .we_i (we_wb), .load_i (load_wb), .store_i (store_wb),
    .data_req_o (data_req_o), .data_we_o (data_we_o), .data_addr_o (data_addr_o),
    .data_wdata_o (data_wdata_o), .data_gnt_i (data_gnt_i),
    .data_rvalid_i (data_rvalid_i), .data_rdata_i (data_rdata_i),
    .hold_o (lsu_hold),
    .wb_we_o (wb_we), .wb_waddr_o (wb_waddr), .wb_wdata_o (wb_wdata)
  );

endmodule

/* verif/riscv_tb_clk_gen.sv */
// Clock and reset source for the core testbench, 8 ns period
module riscv_tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Low over two rising edges, released 1 ns after the second
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/riscv_core_tb.sv */
// Testbench for the RV32I core with program table, bus memory models and store checks
`include "riscv_cfg.svh"

module riscv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import riscv_pkg::*;

  localparam word_t BOOT_ADDR        = 32'h0000_0080;
  localparam int    CYCLES_PER_INSTR = 20;
  // Seed operands, B is -45
  localparam word_t OP_A             = 32'h0000_0123;
  localparam word_t OP_B             = 32'hFFFF_FFD3;

  logic        clk, rst_n;
  logic        instr_req, data_req, data_we, data_gnt, data_rvalid;
  word_t       boot_addr, instr_addr, instr_rdata;
  word_t       data_addr, data_wdata, data_rdata;

  // Program column, then expected stores in program order
  word_t       prog_q[$];
  word_t       exp_addr_q[$];
  word_t       exp_data_q[$];
  word_t       data_mem[word_t];

  int          store_idx;
  int          cycles;
  int          cycle_limit;
  integer      seed;
  logic [31:0] rnd;
  logic        fetch_req, first_fetch_seen, load_granted;
  word_t       fetch_addr, load_addr;

  riscv_tb_clk_gen clk_gen0 (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  riscv_core dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .boot_addr_i   (boot_addr),
    .instr_req_o   (instr_req),
    .instr_addr_o  (instr_addr),
    .instr_rdata_i (instr_rdata),
    .data_req_o    (data_req),
    .data_we_o     (data_we),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_addr_o   (data_addr),
    .data_wdata_o  (data_wdata),
    .data_rdata_i  (data_rdata)
  );

  //////////////////////////////////////////////////////////////////////
  // RV32I rules and instruction encoders
  //////////////////////////////////////////////////////////////////////

  function automatic word_t sext12(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  function automatic word_t lt_signed(word_t a, word_t b);
    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endfunction

  function automatic word_t r_word(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    instr_u w;
    w.r = '{f7, rs2, rs1, f3, rd, OP};
    return w;
  endfunction

  function automatic word_t i_word(opcode_e op, logic [11:0] imm, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd);
    instr_u w;
    w.i = '{imm, rs1, f3, rd, op};
    return w;
  endfunction

  // Upper immediate spread over imm, rs1 and funct3 of the I view
  function automatic word_t u_word(logic [19:0] upper, reg_addr_t rd);
    instr_u w;
    w.i = '{upper[19:8], upper[7:3], upper[2:0], rd, LUI};
    return w;
  endfunction

  function automatic word_t s_word(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
    instr_u w;
    w.s = '{imm[11:5], rs2, rs1, F3_WORD, imm[4:0], STORE};
    return w;
  endfunction

  // SW of rs2 to an address off x0, with the value it must carry
  task automatic expect_store(reg_addr_t rs2, logic [11:0] offset, word_t value);
    prog_q.push_back(s_word(offset, rs2, 5'd0));
    exp_addr_q.push_back(sext12(offset));
    exp_data_q.push_back(value);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Program and expectation table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    word_t slti_v, andi_v, sra_v, c19, c20, c21;
    slti_v = lt_signed(OP_B, sext12(12'd5));
    andi_v = OP_B & sext12(12'h03C);
    // Sign bit copied into the vacated upper bits
    sra_v  = (OP_B >> OP_A[4:0]) | ({32{OP_B[31]}} & ~(32'hFFFF_FFFF >> OP_A[4:0]));
    c19    = 32'd7 + 32'd7;
    c20    = c19 - 32'd7;
    c21    = c20 ^ c19;
    // Immediate ops and LUI
    prog_q.push_back(i_word(OP_IMM, OP_A[11:0], 5'd0, F3_ADD, 5'd1));
    prog_q.push_back(i_word(OP_IMM, OP_B[11:0], 5'd0, F3_ADD, 5'd2));
    prog_q.push_back(i_word(OP_IMM, 12'd5, 5'd2, F3_SLT, 5'd3));
    prog_q.push_back(i_word(OP_IMM, 12'h0F0, 5'd1, F3_XOR, 5'd4));
    prog_q.push_back(i_word(OP_IMM, 12'hF00, 5'd1, F3_OR, 5'd5));
    prog_q.push_back(i_word(OP_IMM, 12'h03C, 5'd2, F3_AND, 5'd6));
    prog_q.push_back(u_word(20'hABCDE, 5'd7));
    expect_store(5'd1, 12'h100, OP_A);
    expect_store(5'd2, 12'h104, OP_B);
    expect_store(5'd3, 12'h108, slti_v);
    expect_store(5'd4, 12'h10C, OP_A ^ sext12(12'h0F0));
    expect_store(5'd5, 12'h110, OP_A | sext12(12'hF00));
    expect_store(5'd6, 12'h114, andi_v);
    expect_store(5'd7, 12'h118, {20'hABCDE, 12'h000});
    // Register ops, negative B for SLT and SRA
    prog_q.push_back(r_word(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd8));
    prog_q.push_back(r_word(F7_ALT, 5'd2, 5'd1, F3_ADD, 5'd9));
    prog_q.push_back(r_word(F7_BASE, 5'd3, 5'd1, F3_SLL, 5'd10));
    prog_q.push_back(r_word(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd11));
    prog_q.push_back(r_word(F7_BASE, 5'd2, 5'd1, F3_XOR, 5'd12));
    prog_q.push_back(r_word(F7_BASE, 5'd6, 5'd2, F3_SR, 5'd13));
    prog_q.push_back(r_word(F7_ALT, 5'd1, 5'd2, F3_SR, 5'd14));
    prog_q.push_back(r_word(F7_BASE, 5'd2, 5'd1, F3_OR, 5'd15));
    prog_q.push_back(r_word(F7_BASE, 5'd2, 5'd1, F3_AND, 5'd16));
    prog_q.push_back(r_word(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd17));
    expect_store(5'd8, 12'h120, OP_A + OP_B);
    expect_store(5'd9, 12'h124, OP_A - OP_B);
    expect_store(5'd10, 12'h128, OP_A << slti_v[4:0]);
    expect_store(5'd11, 12'h12C, lt_signed(OP_B, OP_A));
    expect_store(5'd12, 12'h130, OP_A ^ OP_B);
    expect_store(5'd13, 12'h134, OP_B >> andi_v[4:0]);
    expect_store(5'd14, 12'h138, sra_v);
    expect_store(5'd15, 12'h13C, OP_A | OP_B);
    expect_store(5'd16, 12'h140, OP_A & OP_B);
    expect_store(5'd17, 12'h144, lt_signed(OP_A, OP_B));
    // Dependent chain through EX and write-back forwarding
    prog_q.push_back(i_word(OP_IMM, 12'd7, 5'd0, F3_ADD, 5'd18));
    prog_q.push_back(r_word(F7_BASE, 5'd18, 5'd18, F3_ADD, 5'd19));
    prog_q.push_back(r_word(F7_ALT, 5'd18, 5'd19, F3_ADD, 5'd20));
    prog_q.push_back(r_word(F7_BASE, 5'd19, 5'd20, F3_XOR, 5'd21));
    expect_store(5'd21, 12'h150, c21);
    prog_q.push_back(i_word(OP_IMM, 12'd1, 5'd21, F3_ADD, 5'd22));
    expect_store(5'd22, 12'h154, c21 + 32'd1);
    expect_store(5'd19, 12'h158, c19);
    expect_store(5'd20, 12'h15C, c20);
    // Store, load back and use at once
    prog_q.push_back(i_word(OP_IMM, 12'h055, 5'd0, F3_ADD, 5'd23));
    expect_store(5'd23, 12'h160, 32'h55);
    prog_q.push_back(i_word(LOAD, 12'h160, 5'd0, F3_WORD, 5'd24));
    prog_q.push_back(i_word(OP_IMM, 12'd3, 5'd24, F3_ADD, 5'd25));
    expect_store(5'd25, 12'h164, 32'h55 + 32'd3);
    prog_q.push_back(i_word(LOAD, 12'h104, 5'd0, F3_WORD, 5'd26));
    expect_store(5'd26, 12'h168, OP_B);
    // Writes to x0 are dropped
    prog_q.push_back(i_word(OP_IMM, 12'h077, 5'd0, F3_ADD, 5'd0));
    prog_q.push_back(r_word(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0));
    expect_store(5'd0, 12'h16C, 32'h0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_addr(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Error: %s = 0x%h, expected 0x%h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic check_data(input string name, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("Error: %s = 0x%h, expected 0x%h (store %0d)", name, actual, expected,
               store_idx);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Memory models
  //////////////////////////////////////////////////////////////////////

  // NOP outside the program
  function automatic word_t fetch_word(word_t addr);
    word_t offset;
    word_t w;
    offset = (addr - BOOT_ADDR) >> 2;
    w      = `RV_NOP;
    if (addr >= BOOT_ADDR && offset < word_t'(prog_q.size())) begin
      w = prog_q[offset];
    end
    return w;
  endfunction

  // Unwritten words read back a pattern of their address
  function automatic word_t read_data(word_t addr);
    return data_mem.exists(addr) ? data_mem[addr] : (addr ^ 32'hA5A5_5A5A);
  endfunction

  // Request sampled mid-cycle, word returned 1 ns after the next edge
  initial begin : instr_memory
    instr_rdata      = `RV_NOP;
    first_fetch_seen = 1'b0;
    forever begin
      @(negedge clk);
      fetch_req  = instr_req;
      fetch_addr = instr_addr;
      if (fetch_req && !first_fetch_seen) begin
        check_addr("instr_addr_o", fetch_addr, boot_addr);
        first_fetch_seen = 1'b1;
      end
      @(posedge clk);
      #1;
      if (fetch_req) begin
        instr_rdata = fetch_word(fetch_addr);
      end
    end
  end

  // Random grant, rvalid one cycle after a granted load
  initial begin : data_memory
    seed         = 79;
    store_idx    = 0;
    data_gnt     = 1'b0;
    data_rvalid  = 1'b0;
    data_rdata   = '0;
    load_granted = 1'b0;
    load_addr    = '0;
    forever begin
      @(negedge clk);
      load_granted = 1'b0;
      if (data_req && data_gnt) begin
        if (!data_we) begin
          load_granted = 1'b1;
          load_addr    = data_addr;
        end else if (store_idx >= exp_addr_q.size()) begin
          $display("Store to 0x%h after the last expected store", data_addr);
          abort_run();
        end else begin
          // Next table entry, one per granted store
          check_addr("data_addr_o", data_addr, exp_addr_q[store_idx]);
          check_data("data_wdata_o", data_wdata, exp_data_q[store_idx]);
          data_mem[data_addr] = data_wdata;
          store_idx++;
        end
      end
      @(posedge clk);
      #1;
      data_rvalid = load_granted;
      data_rdata  = load_granted ? read_data(load_addr) : '0;
      rnd         = $random(seed);
      // Grant about three cycles in four
      data_gnt    = (rnd[1:0] != 2'b00);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  initial begin : main_sequence
    boot_addr = BOOT_ADDR;
    cycles    = 0;
    build_table();
    cycle_limit = CYCLES_PER_INSTR * prog_q.size();
    @(posedge rst_n);
    while (store_idx < exp_addr_q.size() && cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (store_idx == exp_addr_q.size()) begin
      $display("%0d stores checked in %0d cycles", store_idx, cycles);
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      $display("Timeout after %0d cycles with %0d of %0d stores seen", cycles, store_idx,
               exp_addr_q.size());
      abort_run();
    end
  end

endmodule

/* riscv_core.f */
+incdir+src
src/riscv_pkg.sv
src/riscv_register_file.sv
src/riscv_if_stage.sv
src/riscv_id_stage.sv
src/riscv_ex_stage.sv
src/riscv_load_store_unit.sv
src/riscv_core.sv
verif/riscv_tb_clk_gen.sv
verif/riscv_core_tb.sv

/* Makefile */
TOP := riscv_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) \
		-f riscv_core.f -Mdir obj_dir -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qF '*** TEST PASSED ***' sim.log

lint:
	verilator --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f riscv_core.f

clean:
	rm -rf obj_dir sim.log
